/* Bender.yml */
package:
  name: median3x3

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pix_pkg.sv
      - hdl/win_pkg.sv
      - hdl/sort3.sv
      - hdl/row_sort_stage.sv
      - hdl/median_select_stage.sv
      - hdl/median3x3_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/median3x3_tb.sv

/* hdl/median3x3_top.sv */
`timescale 1ns/1ps
`default_nettype none

// 3x3 median filter core.
// one window per clock, three cycles of latency, no back-pressure.
module median3x3_top
    import pix_pkg::*;
    import win_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // window in, indexed row first.
    input  logic    valid_i,
    input  window_t window_i,

    // median of the window, three cycles after it was sampled.
    output logic    valid_o,
    output pix_t    median_o
);

    logic    rows_valid;
    window_t rows_win;
    window_t rows_win_tr;

    logic    cols_valid;
    window_t cols_win;

    // ======================================================================
    // pass 1: sort each row
    // ======================================================================

    row_sort_stage u_rows (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .win_i   (window_i),
        .valid_o (rows_valid),
        .win_o   (rows_win)
    );

    // transpose so the columns appear as rows.
    // no logic, only wiring.
    genvar r;
    genvar c;

    generate
        for (r = 0; r < WIN_N; r++) begin : g_tr_row
            for (c = 0; c < WIN_N; c++) begin : g_tr_col
                assign rows_win_tr[c][r] = rows_win[r][c];
            end
        end
    endgenerate

    // ======================================================================
    // pass 2: sort each column
    // ======================================================================

    row_sort_stage u_cols (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rows_valid),
        .win_i   (rows_win_tr),
        .valid_o (cols_valid),
        .win_o   (cols_win)
    );

    // ======================================================================
    // median pick
    // ======================================================================

    // cols_win is still transposed. the anti-diagonal maps onto itself,
    // so it can be read directly.
    median_select_stage u_sel (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (cols_valid),
        .win_i    (cols_win),
        .valid_o  (valid_o),
        .median_o (median_o)
    );

endmodule

`default_nettype wire

/* hdl/median_defs.svh */
`ifndef MEDIAN_DEFS_SVH
`define MEDIAN_DEFS_SVH

// ==========================================================================
// pixel and window geometry
// ==========================================================================

// bit width of one pixel.
`define MED_PIX_W 8

// side length of the square window.
// the sorting network is built for three elements per row,
// so this stays at 3.
`define MED_WIN_N 3

`endif

/* hdl/median_select_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// last stage: median of the anti-diagonal.
// after rows and columns are sorted, the median of the nine pixels
// equals the median of these three entries.
module median_select_stage
    import pix_pkg::*;
    import win_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    valid_i,
    input  window_t win_i,
    output logic    valid_o,
    output pix_t    median_o
);

    row_t diag;
    row_t diag_sorted;

    // row 0 col 2, row 1 col 1, row 2 col 0.
    genvar i;

    generate
        for (i = 0; i < WIN_N; i++) begin : g_diag
            assign diag[i] = win_i[i][WIN_N-1-i];
        end
    endgenerate

    sort3 u_sort (
        .in_i     (diag),
        .sorted_o (diag_sorted)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o  <= 1'b0;
            median_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                median_o <= diag_sorted[MID_IDX];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pix_pkg.sv */
`default_nettype none

`include "median_defs.svh"

// types for a single pixel.
package pix_pkg;

    // unsigned grey level, compared as an unsigned number.
    typedef logic [`MED_PIX_W-1:0] pix_t;

endpackage

`default_nettype wire

/* hdl/row_sort_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// one pipeline stage that sorts every row of a window.
// used once for the rows and once, behind a transpose, for the columns.
module row_sort_stage
    import win_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // window in.
    input  logic    valid_i,
    input  window_t win_i,

    // sorted window out, one cycle later.
    output logic    valid_o,
    output window_t win_o
);

    // ======================================================================
    // sorting network per row
    // ======================================================================

    window_t sorted;

    genvar r;

    generate
        for (r = 0; r < WIN_N; r++) begin : g_row
            sort3 u_sort (
                .in_i     (win_i[r]),
                .sorted_o (sorted[r])
            );
        end
    endgenerate

    // ======================================================================
    // stage register
    // ======================================================================

    // valid follows the input on every cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // data only moves with a valid window.
    // idle cycles leave the last result in place.
    always_ff @(posedge clk) begin
        if (rst) begin
            win_o <= '0;
        end else if (valid_i) begin
            win_o <= sorted;
        end
    end

endmodule

`default_nettype wire

/* hdl/sort3.sv */
`timescale 1ns/1ps
`default_nettype none

// three-input sorting network, purely combinational.
// output is ascending: element 0 is the minimum.
module sort3
    import pix_pkg::*;
    import win_pkg::*;
(
    input  row_t in_i,
    output row_t sorted_o
);

    logic swap_a;
    logic swap_b;
    logic swap_c;
    pix_t a_lo;
    pix_t a_hi;
    pix_t b_lo;
    pix_t b_hi;
    pix_t c_lo;
    pix_t c_hi;

    // exchange on elements 0 and 1.
    // only a strict greater-than swaps, so equal values keep their order.
    assign swap_a = in_i[0] > in_i[1];
    assign a_lo   = swap_a ? in_i[1] : in_i[0];
    assign a_hi   = swap_a ? in_i[0] : in_i[1];

    // larger of the first pair against element 2 gives the maximum.
    assign swap_b = a_hi > in_i[2];
    assign b_lo   = swap_b ? in_i[2] : a_hi;
    assign b_hi   = swap_b ? a_hi : in_i[2];

    // the two remaining values give minimum and middle.
    assign swap_c = a_lo > b_lo;
    assign c_lo   = swap_c ? b_lo : a_lo;
    assign c_hi   = swap_c ? a_lo : b_lo;

    assign sorted_o[0] = c_lo;
    assign sorted_o[1] = c_hi;
    assign sorted_o[2] = b_hi;

endmodule

`default_nettype wire

/* hdl/win_pkg.sv */
`default_nettype none

`include "median_defs.svh"

// window geometry built from pixels.
package win_pkg;

    import pix_pkg::*;

    // ======================================================================
    // sizes
    // ======================================================================

    // side length of the window.
    localparam int unsigned WIN_N = `MED_WIN_N;

    // position of the middle element in a sorted row.
    localparam int unsigned MID_IDX = WIN_N / 2;

    // ======================================================================
    // types
    // ======================================================================

    // one row, one column or the anti-diagonal triple.
    // element 0 sits in the low bits.
    typedef pix_t [WIN_N-1:0] row_t;

    // full window, indexed row first: win[row][col].
    typedef row_t [WIN_N-1:0] window_t;

endpackage

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/pix_pkg.sv
hdl/win_pkg.sv
hdl/sort3.sv
hdl/row_sort_stage.sv
hdl/median_select_stage.sv
hdl/median3x3_top.sv
verification/median3x3_tb.sv

/* verification/median3x3_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "median_defs.svh"

module median3x3_tb
    import pix_pkg::*;
    import win_pkg::*;
;

    // ======================================================================
    // test sizes and run limit
    // ======================================================================

    localparam int NPIX         = `MED_WIN_N * `MED_WIN_N;
    localparam int PIX_MAX      = (1 << `MED_PIX_W) - 1;
    localparam int LATENCY      = 3;
    localparam int RESET_CYCLES = 16;
    localparam int LEAD_IDLE    = 2;
    localparam int N_RANDOM     = 400;
    localparam int MAX_GAP      = 3;
    localparam int N_BURST      = 20;
    localparam int N_CORNER     = 25;
    localparam int DRAIN_CYCLES = LATENCY + 2;
    localparam int MARGIN       = 50;
    localparam int RUN_LIMIT    = RESET_CYCLES + LEAD_IDLE + N_RANDOM * (1 + MAX_GAP)
                                  + N_BURST + N_CORNER + DRAIN_CYCLES + MARGIN;

    logic    clk;
    logic    rst;
    logic    valid_i;
    window_t window_i;
    logic    valid_o;
    pix_t    median_o;

    // scoreboard and expected values.
    pix_t             sb [$];
    pix_t             exp_median   = '0;
    logic [LATENCY-1:0] exp_valid  = '0;
    logic             checks_on    = 1'b0;
    logic             seen_result  = 1'b0;
    logic             sb_underflow = 1'b0;
    int               sent_count   = 0;
    int               results_seen = 0;
    int               cycle_count  = 0;
    int               value_errors = 0;
    int               other_errors = 0;

    median3x3_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (valid_i),
        .window_i (window_i),
        .valid_o  (valid_o),
        .median_o (median_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ======================================================================
    // reference model and helpers
    // ======================================================================

    // full sort of all nine pixels, then the fifth one.
    function automatic pix_t true_median(input window_t w);
        pix_t vals [NPIX];
        pix_t tmp;
        int   k;
        int   j;
        for (k = 0; k < NPIX; k++) begin
            vals[k] = w[k / `MED_WIN_N][k % `MED_WIN_N];
        end
        for (k = 1; k < NPIX; k++) begin
            tmp = vals[k];
            j = k - 1;
            while (j >= 0 && vals[j] > tmp) begin
                vals[j + 1] = vals[j];
                j--;
            end
            vals[j + 1] = tmp;
        end
        return vals[NPIX / 2];
    endfunction

    // list order is row major.
    function automatic window_t from_list(input pix_t v [NPIX]);
        window_t w;
        int      k;
        for (k = 0; k < NPIX; k++) begin
            w[k / `MED_WIN_N][k % `MED_WIN_N] = v[k];
        end
        return w;
    endfunction

    function automatic window_t random_window();
        window_t w;
        int      k;
        for (k = 0; k < NPIX; k++) begin
            w[k / `MED_WIN_N][k % `MED_WIN_N] = pix_t'($urandom);
        end
        return w;
    endfunction

    task automatic send_window(input window_t w);
        @(posedge clk);
        #1;
        valid_i  = 1'b1;
        window_i = w;
        sb.push_back(true_median(w));
        sent_count++;
    endtask

    // idle cycles carry junk data that must not show up anywhere.
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        valid_i  = 1'b0;
        window_i = random_window();
    endtask

    // ======================================================================
    // expected valid and scoreboard pop
    // ======================================================================

    always @(posedge clk) begin
        if (rst) begin
            exp_valid <= '0;
        end else begin
            exp_valid <= {exp_valid[LATENCY-2:0], valid_i};
        end
    end

    // outputs are settled at the falling edge, so the head is taken here.
    always @(negedge clk) begin
        checks_on    = 1'b1;
        sb_underflow = 1'b0;
        if (valid_o === 1'b1) begin
            results_seen++;
            seen_result = 1'b1;
            if (sb.size() == 0) begin
                sb_underflow = 1'b1;
            end else begin
                exp_median = sb.pop_front();
            end
        end
    end

    // ======================================================================
    // checks
    // ======================================================================

    reset_idle_chk: assert property (@(posedge clk) disable iff (!checks_on)
        (rst || !seen_result) |-> (valid_o == 1'b0 && median_o == '0))
    else begin
        value_errors++;
        $display("Mismatch at %0t: valid_o/median_o expected 0/0, got %0b/%0d",
                 $time, $sampled(valid_o), $sampled(median_o));
    end

    valid_latency_chk: assert property (@(posedge clk) disable iff (!checks_on)
        valid_o == exp_valid[LATENCY-1])
    else begin
        value_errors++;
        $display("Mismatch at %0t: valid_o expected %0b, got %0b",
                 $time, $sampled(exp_valid[LATENCY-1]), $sampled(valid_o));
    end

    median_value_chk: assert property (@(posedge clk) disable iff (!checks_on)
        valid_o |-> median_o == exp_median)
    else begin
        value_errors++;
        $display("Mismatch at %0t: median_o expected %0d, got %0d",
                 $time, $sampled(exp_median), $sampled(median_o));
    end

    no_extra_result_chk: assert property (@(posedge clk) disable iff (!checks_on)
        !sb_underflow)
    else begin
        other_errors++;
        $display("unexpected result at %0t: valid_o high with no window pending", $time);
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    initial begin : stimulus
        pix_t vals [NPIX];
        int   i;
        int   k;
        int   gap;

        void'($urandom(33));
        rst      = 1'b1;
        valid_i  = 1'b0;
        window_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (LEAD_IDLE) idle_cycle();

        // random windows with random idle gaps.
        for (i = 0; i < N_RANDOM; i++) begin
            send_window(random_window());
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) idle_cycle();
        end

        // back-to-back burst.
        for (i = 0; i < N_BURST; i++) begin
            send_window(random_window());
        end

        // all pixels equal.
        for (i = 0; i < 3; i++) begin
            for (k = 0; k < NPIX; k++) begin
                vals[k] = pix_t'(i * PIX_MAX / 2);
            end
            send_window(from_list(vals));
        end

        // one outlier in a flat field, at every position.
        for (i = 0; i < NPIX; i++) begin
            for (k = 0; k < NPIX; k++) begin
                vals[k] = (k == i) ? pix_t'(PIX_MAX) : pix_t'(0);
            end
            send_window(from_list(vals));
            for (k = 0; k < NPIX; k++) begin
                vals[k] = (k == i) ? pix_t'(0) : pix_t'(PIX_MAX);
            end
            send_window(from_list(vals));
        end

        // many duplicates.
        vals = '{5, 5, 5, 9, 9, 1, 1, 9, 5};
        send_window(from_list(vals));
        vals = '{200, 200, 3, 3, 200, 3, 3, 200, 3};
        send_window(from_list(vals));

        // already sorted, both directions.
        for (k = 0; k < NPIX; k++) begin
            vals[k] = pix_t'(10 * (k + 1));
        end
        send_window(from_list(vals));
        for (k = 0; k < NPIX; k++) begin
            vals[k] = pix_t'(250 - 10 * k);
        end
        send_window(from_list(vals));

        // the pipeline depth is fixed, so this drains it.
        repeat (DRAIN_CYCLES) idle_cycle();

        scoreboard_empty_chk: assert (sb.size() == 0)
        else begin
            other_errors++;
            $display("missing result: %0d windows never produced an output", sb.size());
        end

        result_count_chk: assert (results_seen == sent_count)
        else begin
            other_errors++;
            $display("result count wrong: %0d windows sent, %0d results seen",
                     sent_count, results_seen);
        end

        $display("error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= RUN_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire
